// ==== bench/rib_tb.sv ====
module rib_tb
    import rib_pkg::*;
();

    logic  clk;
    logic  rst_n;
    integer seed;

    logic  m0_wr_req;
    logic  m0_wr_en;
    addr_t m0_wr_addr;
    data_t m0_wr_data;
    logic  m0_rd_req;
    addr_t m0_rd_addr;
    data_t m0_rd_data;
    logic  m1_wr_req;
    logic  m1_wr_en;
    addr_t m1_wr_addr;
    data_t m1_wr_data;
    logic  hold_flag;

    logic  [num_slaves-1:0] s_wr_en;
    addr_t [num_slaves-1:0] s_wr_addr;
    data_t [num_slaves-1:0] s_wr_data;
    addr_t [num_slaves-1:0] s_rd_addr;
    data_t [num_slaves-1:0] s_rd_data;

    // expected values from the address map
    logic                   g_en;
    addr_t                  g_addr;
    data_t                  g_data;
    logic  [num_slaves-1:0] exp_wr_en;
    addr_t [num_slaves-1:0] exp_wr_addr;
    data_t [num_slaves-1:0] exp_wr_data;
    addr_t [num_slaves-1:0] exp_rd_addr;
    data_t                  exp_rd_data;    // word due this cycle
    logic                   past_valid;

    int value_errors;
    int timeout_errors;
    int coverage_errors;
    int core_hits;
    int debug_hits;
    int unmapped_hits;
    int read_hits;

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    rib dut_i
    (
        .clk (clk), .rst_n_i (rst_n),
        .m0_wr_req_i (m0_wr_req), .m0_wr_en_i (m0_wr_en),
        .m0_wr_addr_i (m0_wr_addr), .m0_wr_data_i (m0_wr_data),
        .m0_rd_req_i (m0_rd_req), .m0_rd_addr_i (m0_rd_addr), .m0_rd_data_o (m0_rd_data),
        .m1_wr_req_i (m1_wr_req), .m1_wr_en_i (m1_wr_en),
        .m1_wr_addr_i (m1_wr_addr), .m1_wr_data_i (m1_wr_data),
        .s0_wr_en_o (s_wr_en[0]), .s0_wr_addr_o (s_wr_addr[0]), .s0_wr_data_o (s_wr_data[0]),
        .s0_rd_addr_o (s_rd_addr[0]), .s0_rd_data_i (s_rd_data[0]),
        .s1_wr_en_o (s_wr_en[1]), .s1_wr_addr_o (s_wr_addr[1]), .s1_wr_data_o (s_wr_data[1]),
        .s1_rd_addr_o (s_rd_addr[1]), .s1_rd_data_i (s_rd_data[1]),
        .s2_wr_en_o (s_wr_en[2]), .s2_wr_addr_o (s_wr_addr[2]), .s2_wr_data_o (s_wr_data[2]),
        .s2_rd_addr_o (s_rd_addr[2]), .s2_rd_data_i (s_rd_data[2]),
        .s3_wr_en_o (s_wr_en[3]), .s3_wr_addr_o (s_wr_addr[3]), .s3_wr_data_o (s_wr_data[3]),
        .s3_rd_addr_o (s_rd_addr[3]), .s3_rd_data_i (s_rd_data[3]),
        .s4_wr_en_o (s_wr_en[4]), .s4_wr_addr_o (s_wr_addr[4]), .s4_wr_data_o (s_wr_data[4]),
        .s4_rd_addr_o (s_rd_addr[4]), .s4_rd_data_i (s_rd_data[4]),
        .rib_hold_flag_o (hold_flag)
    );

    // slave index of an address, -1 when unmapped
    function automatic int slave_of(addr_t addr);
        region_t r;
        r = addr[31:28];
        if (r < num_slaves)
        begin
            return int'(r);
        end
        return -1;
    endfunction

    function automatic addr_t offset_of(addr_t addr);
        return {4'h0, addr[27:0]};
    endfunction

    function automatic data_t read_word(addr_t addr, logic live);
        if (!live || slave_of(addr) < 0)
        begin
            return '0;
        end
        return {addr[31:28], addr[27:0]};   // model puts its index on top
    endfunction

    always_comb
    begin
        g_en   = m1_wr_req ? m1_wr_en : m0_wr_en;     // debug wins
        g_addr = m1_wr_req ? m1_wr_addr : m0_wr_addr;
        g_data = m1_wr_req ? m1_wr_data : m0_wr_data;
        for (int i = 0; i < num_slaves; i++)
        begin
            exp_wr_en[i]   = (slave_of(g_addr) == i) ? g_en : 1'b0;
            exp_wr_addr[i] = (slave_of(g_addr) == i) ? offset_of(g_addr) : '0;
            exp_wr_data[i] = (slave_of(g_addr) == i) ? g_data : '0;
            exp_rd_addr[i] = (slave_of(m0_rd_addr) == i) ? offset_of(m0_rd_addr) : '0;
        end
    end

    always @(posedge clk)
    begin
        past_valid  <= 1'b1;
        exp_rd_data <= read_word(m0_rd_addr, rst_n);
        if (rst_n)
        begin
            core_hits     = core_hits + ((!m1_wr_req && slave_of(m0_wr_addr) >= 0) ? 1 : 0);
            debug_hits    = debug_hits + ((m1_wr_req && m0_wr_en) ? 1 : 0);
            unmapped_hits = unmapped_hits + ((slave_of(g_addr) < 0) ? 1 : 0);
            read_hits     = read_hits + ((slave_of(m0_rd_addr) >= 0) ? 1 : 0);
        end
    end

    for (genvar i = 0; i < num_slaves; i++)
    begin : slave_gen
        rib_tb_slaves #(.slave_idx(i)) model_i
        (
            .clk       (clk),
            .rd_addr_i (s_rd_addr[i]),
            .rd_data_o (s_rd_data[i])
        );

        assert property (@(posedge clk) s_wr_en[i] == exp_wr_en[i])
        else
        begin
            value_errors++;
            $display("FAIL write_enable s%0d expected %0h actual %0h",
                     i, $sampled(exp_wr_en[i]), $sampled(s_wr_en[i]));
        end

        assert property (@(posedge clk) s_wr_addr[i] == exp_wr_addr[i])
        else
        begin
            value_errors++;
            $display("FAIL write_address s%0d expected %0h actual %0h",
                     i, $sampled(exp_wr_addr[i]), $sampled(s_wr_addr[i]));
        end

        assert property (@(posedge clk) s_wr_data[i] == exp_wr_data[i])
        else
        begin
            value_errors++;
            $display("FAIL write_data s%0d expected %0h actual %0h",
                     i, $sampled(exp_wr_data[i]), $sampled(s_wr_data[i]));
        end

        assert property (@(posedge clk) s_rd_addr[i] == exp_rd_addr[i])
        else
        begin
            value_errors++;
            $display("FAIL read_address s%0d expected %0h actual %0h",
                     i, $sampled(exp_rd_addr[i]), $sampled(s_rd_addr[i]));
        end
    end

    assert property (@(posedge clk) hold_flag == m1_wr_req)
    else
    begin
        value_errors++;
        $display("FAIL hold_flag expected %0h actual %0h", $sampled(m1_wr_req),
                 $sampled(hold_flag));
    end

    assert property (@(posedge clk) past_valid |-> m0_rd_data == exp_rd_data)
    else
    begin
        value_errors++;
        $display("FAIL read_return expected %0h actual %0h", $sampled(exp_rd_data),
                 $sampled(m0_rd_data));
    end

    task automatic drive_random();
        logic [31:0] bits;
        bits = $random(seed);
        m0_wr_req  <= bits[0];
        m0_wr_en   <= bits[1];
        m1_wr_req  <= bits[2];
        m1_wr_en   <= bits[3];
        m0_rd_req  <= bits[4];
        m0_wr_addr <= $random(seed);    // all 16 regions
        m0_wr_data <= $random(seed);
        m1_wr_addr <= $random(seed);
        m1_wr_data <= $random(seed);
        m0_rd_addr <= $random(seed);
    endtask

    // outputs looked at on the falling edge
    task automatic wait_for_read(input data_t want, input int limit);
        int n;
        n = 0;
        while (m0_rd_data !== want && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (m0_rd_data !== want)
        begin
            timeout_errors++;
            $display("timeout: read data never came back from the addressed slave");
        end
    endtask

    task automatic check_reach(input int hits, input string what);
        if (hits == 0)
        begin
            coverage_errors++;
            $display("stimulus never produced a %s cycle", what);
        end
    endtask

    initial
    begin
        repeat (5000) @(posedge clk);
        $display("timeout: simulation ran past its cycle limit");
        $display("errors: value %0d timeout %0d coverage %0d",
                 value_errors, timeout_errors + 1, coverage_errors);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        seed = 66743;
        value_errors = 0;
        timeout_errors = 0;
        coverage_errors = 0;
        core_hits = 0;
        debug_hits = 0;
        unmapped_hits = 0;
        read_hits = 0;
        past_valid = 1'b0;
        exp_rd_data = '0;
        rst_n = 1'b0;
        m0_wr_req = 1'b0;
        m0_wr_en = 1'b0;
        m0_wr_addr = '0;
        m0_wr_data = '0;
        m0_rd_req = 1'b0;
        m0_rd_addr = '0;
        m1_wr_req = 1'b0;
        m1_wr_en = 1'b0;
        m1_wr_addr = '0;
        m1_wr_data = '0;

        for (int c = 0; c < 10; c++)
        begin
            @(posedge clk);
            drive_random();     // reads during reset must still return zero
        end
        rst_n <= 1'b1;

        for (int c = 0; c < 400; c++)
        begin
            @(posedge clk);
            drive_random();
        end

        // a timer read, then a rom read
        @(posedge clk);
        m0_rd_addr <= 32'h4123_4567;
        wait_for_read(32'h4123_4567, 8);
        @(posedge clk);
        m0_rd_addr <= 32'h0000_0abc;
        wait_for_read(32'h0000_0abc, 8);

        @(posedge clk);
        @(negedge clk);
        check_reach(core_hits, "core write");
        check_reach(debug_hits, "debug write");
        check_reach(unmapped_hits, "unmapped write");
        check_reach(read_hits, "mapped read");

        $display("errors: value %0d timeout %0d coverage %0d",
                 value_errors, timeout_errors, coverage_errors);
        if (value_errors == 0 && timeout_errors == 0 && coverage_errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/rib_tb_slaves.sv ====
module rib_tb_slaves
    import rib_pkg::*;
#(
    parameter int slave_idx = 0
)
(
    input  logic  clk,

    input  addr_t rd_addr_i,
    output data_t rd_data_o
);

    addr_t rd_addr_q;       // answers one clock after the request

    always_ff @(posedge clk)
    begin
        rd_addr_q <= rd_addr_i;
    end

    // index on top, registered offset below
    assign rd_data_o = {region_t'(slave_idx), rd_addr_q[offset_w-1:0]};

endmodule

// ==== logic/rib.sv ====
module rib
    import rib_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,

    // master 0, core memory stage
    input  logic  m0_wr_req_i,       // no effect on the grant
    input  logic  m0_wr_en_i,
    input  addr_t m0_wr_addr_i,
    input  data_t m0_wr_data_i,
    input  logic  m0_rd_req_i,       // only reader, never arbitrated
    input  addr_t m0_rd_addr_i,
    output data_t m0_rd_data_o,

    // master 1, debug port
    input  logic  m1_wr_req_i,
    input  logic  m1_wr_en_i,
    input  addr_t m1_wr_addr_i,
    input  data_t m1_wr_data_i,

    // rom
    output logic  s0_wr_en_o,
    output addr_t s0_wr_addr_o,
    output data_t s0_wr_data_o,
    output addr_t s0_rd_addr_o,
    input  data_t s0_rd_data_i,

    // ram
    output logic  s1_wr_en_o,
    output addr_t s1_wr_addr_o,
    output data_t s1_wr_data_o,
    output addr_t s1_rd_addr_o,
    input  data_t s1_rd_data_i,

    // uart
    output logic  s2_wr_en_o,
    output addr_t s2_wr_addr_o,
    output data_t s2_wr_data_o,
    output addr_t s2_rd_addr_o,
    input  data_t s2_rd_data_i,

    // gpio
    output logic  s3_wr_en_o,
    output addr_t s3_wr_addr_o,
    output data_t s3_wr_data_o,
    output addr_t s3_rd_addr_o,
    input  data_t s3_rd_data_i,

    // timer
    output logic  s4_wr_en_o,
    output addr_t s4_wr_addr_o,
    output data_t s4_wr_data_o,
    output addr_t s4_rd_addr_o,
    input  data_t s4_rd_data_i,

    output logic  rib_hold_flag_o    // stall request to the core
);

    logic  [num_slaves-1:0] s_wr_en;
    addr_t [num_slaves-1:0] s_wr_addr;
    data_t [num_slaves-1:0] s_wr_data;
    addr_t [num_slaves-1:0] s_rd_addr;
    data_t [num_slaves-1:0] s_rd_data;

    rib_wr_path wr_path_i
    (
        .m0_wr_en_i   (m0_wr_en_i),
        .m0_wr_addr_i (m0_wr_addr_i),
        .m0_wr_data_i (m0_wr_data_i),
        .m1_wr_req_i  (m1_wr_req_i),
        .m1_wr_en_i   (m1_wr_en_i),
        .m1_wr_addr_i (m1_wr_addr_i),
        .m1_wr_data_i (m1_wr_data_i),
        .s_wr_en_o    (s_wr_en),
        .s_wr_addr_o  (s_wr_addr),
        .s_wr_data_o  (s_wr_data),
        .hold_o       (rib_hold_flag_o)
    );

    rib_rd_path rd_path_i
    (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .m0_rd_addr_i (m0_rd_addr_i),
        .m0_rd_data_o (m0_rd_data_o),
        .s_rd_addr_o  (s_rd_addr),
        .s_rd_data_i  (s_rd_data)
    );

    // fan the slave vectors out to named ports
    assign s0_wr_en_o   = s_wr_en[0];
    assign s0_wr_addr_o = s_wr_addr[0];
    assign s0_wr_data_o = s_wr_data[0];
    assign s0_rd_addr_o = s_rd_addr[0];

    assign s1_wr_en_o   = s_wr_en[1];
    assign s1_wr_addr_o = s_wr_addr[1];
    assign s1_wr_data_o = s_wr_data[1];
    assign s1_rd_addr_o = s_rd_addr[1];

    assign s2_wr_en_o   = s_wr_en[2];
    assign s2_wr_addr_o = s_wr_addr[2];
    assign s2_wr_data_o = s_wr_data[2];
    assign s2_rd_addr_o = s_rd_addr[2];

    assign s3_wr_en_o   = s_wr_en[3];
    assign s3_wr_addr_o = s_wr_addr[3];
    assign s3_wr_data_o = s_wr_data[3];
    assign s3_rd_addr_o = s_rd_addr[3];

    assign s4_wr_en_o   = s_wr_en[4];
    assign s4_wr_addr_o = s_wr_addr[4];
    assign s4_wr_data_o = s_wr_data[4];
    assign s4_rd_addr_o = s_rd_addr[4];

    assign s_rd_data[0] = s0_rd_data_i;
    assign s_rd_data[1] = s1_rd_data_i;
    assign s_rd_data[2] = s2_rd_data_i;
    assign s_rd_data[3] = s3_rd_data_i;
    assign s_rd_data[4] = s4_rd_data_i;

endmodule

// ==== logic/rib_pkg.sv ====
package rib_pkg;

    // widths of the bus
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  region_t;    // top address nibble

    localparam int offset_w   = 28;   // offset bits seen by a slave
    localparam int num_slaves = 5;

    // slave map, one 256 MB window per region
    localparam region_t region_rom   = 4'd0;  // 0x0000_0000 .. 0x0fff_ffff
    localparam region_t region_ram   = 4'd1;  // 0x1000_0000 .. 0x1fff_ffff
    localparam region_t region_uart  = 4'd2;  // 0x2000_0000 .. 0x2fff_ffff
    localparam region_t region_gpio  = 4'd3;  // 0x3000_0000 .. 0x3fff_ffff
    localparam region_t region_timer = 4'd4;  // 0x4000_0000 .. 0x4fff_ffff

    // no slave lives here
    localparam region_t region_none  = 4'd15;

    // write arbitration result, debug has priority
    typedef enum logic
    {
        grant_core  = 1'b0,
        grant_debug = 1'b1
    } wr_grant_e;

endpackage

// ==== logic/rib_rd_path.sv ====
module rib_rd_path
    import rib_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  addr_t                        m0_rd_addr_i,
    output data_t                        m0_rd_data_o,

    output addr_t [num_slaves-1:0]       s_rd_addr_o,
    input  data_t [num_slaves-1:0]       s_rd_data_i
);

    region_t               rd_region;
    region_t               rd_tag;           // region of last cycle's read
    addr_t                 rd_offset;
    logic [num_slaves-1:0] rd_sel;

    assign rd_region = m0_rd_addr_i[offset_w +: $bits(region_t)];
    assign rd_offset = {{($bits(addr_t) - offset_w){1'b0}}, m0_rd_addr_i[offset_w-1:0]};

    always_comb
    begin
        rd_sel = '0;
        case (rd_region)
            region_rom:
            begin
                rd_sel[0] = 1'b1;
            end
            region_ram:
            begin
                rd_sel[1] = 1'b1;
            end
            region_uart:
            begin
                rd_sel[2] = 1'b1;
            end
            region_gpio:
            begin
                rd_sel[3] = 1'b1;
            end
            region_timer:
            begin
                rd_sel[4] = 1'b1;
            end
            default:
            begin
                rd_sel = '0;
            end
        endcase
    end

    // address goes out in the same cycle
    always_comb
    begin
        for (int i = 0; i < num_slaves; i++)
        begin
            if (rd_sel[i])
            begin
                s_rd_addr_o[i] = rd_offset;
            end
            else
            begin
                s_rd_addr_o[i] = '0;
            end
        end
    end

    // slaves answer one clock later, so remember who was asked
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            rd_tag <= region_none;
        end
        else
        begin
            rd_tag <= rd_region;
        end
    end

    always_comb
    begin
        case (rd_tag)
            region_rom:
            begin
                m0_rd_data_o = s_rd_data_i[0];
            end
            region_ram:
            begin
                m0_rd_data_o = s_rd_data_i[1];
            end
            region_uart:
            begin
                m0_rd_data_o = s_rd_data_i[2];
            end
            region_gpio:
            begin
                m0_rd_data_o = s_rd_data_i[3];
            end
            region_timer:
            begin
                m0_rd_data_o = s_rd_data_i[4];
            end
            default:
            begin
                m0_rd_data_o = '0;              // unmapped or just out of reset
            end
        endcase
    end

endmodule

// ==== logic/rib_wr_path.sv ====
module rib_wr_path
    import rib_pkg::*;
(
    input  logic                         m0_wr_en_i,
    input  addr_t                        m0_wr_addr_i,
    input  data_t                        m0_wr_data_i,

    input  logic                         m1_wr_req_i,
    input  logic                         m1_wr_en_i,
    input  addr_t                        m1_wr_addr_i,
    input  data_t                        m1_wr_data_i,

    output logic  [num_slaves-1:0]       s_wr_en_o,
    output addr_t [num_slaves-1:0]       s_wr_addr_o,
    output data_t [num_slaves-1:0]       s_wr_data_o,

    output logic                         hold_o
);

    wr_grant_e             grant;
    logic                  wr_en;
    addr_t                 wr_addr;
    data_t                 wr_data;
    region_t               wr_region;
    addr_t                 wr_offset;
    logic [num_slaves-1:0] wr_sel;

    // fixed priority, debug over core
    always_comb
    begin
        if (m1_wr_req_i)
        begin
            grant = grant_debug;
        end
        else
        begin
            grant = grant_core;
        end
    end

    // core stalls while debug writes
    assign hold_o = m1_wr_req_i;

    always_comb
    begin
        case (grant)
            grant_debug:
            begin
                wr_en   = m1_wr_en_i;
                wr_addr = m1_wr_addr_i;
                wr_data = m1_wr_data_i;
            end
            default:
            begin
                wr_en   = m0_wr_en_i;
                wr_addr = m0_wr_addr_i;
                wr_data = m0_wr_data_i;
            end
        endcase
    end

    assign wr_region = wr_addr[offset_w +: $bits(region_t)];
    assign wr_offset = {{($bits(addr_t) - offset_w){1'b0}}, wr_addr[offset_w-1:0]};

    // one-hot slave select, unmapped leaves it empty
    always_comb
    begin
        wr_sel = '0;
        case (wr_region)
            region_rom:
            begin
                wr_sel[0] = 1'b1;
            end
            region_ram:
            begin
                wr_sel[1] = 1'b1;
            end
            region_uart:
            begin
                wr_sel[2] = 1'b1;
            end
            region_gpio:
            begin
                wr_sel[3] = 1'b1;
            end
            region_timer:
            begin
                wr_sel[4] = 1'b1;
            end
            default:
            begin
                wr_sel = '0;
            end
        endcase
    end

    // steer the granted write, other slaves see zero
    always_comb
    begin
        for (int i = 0; i < num_slaves; i++)
        begin
            if (wr_sel[i])
            begin
                s_wr_en_o[i]   = wr_en;         // level from the master, not the req
                s_wr_addr_o[i] = wr_offset;
                s_wr_data_o[i] = wr_data;
            end
            else
            begin
                s_wr_en_o[i]   = 1'b0;
                s_wr_addr_o[i] = '0;
                s_wr_data_o[i] = '0;
            end
        end
    end

endmodule

// ==== src.f ====
logic/rib_pkg.sv
logic/rib_wr_path.sv
logic/rib_rd_path.sv
logic/rib.sv
bench/rib_tb_slaves.sv
bench/rib_tb.sv
